//--- mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_JR   = 6'h08;
    localparam logic [5:0] FN_JALR = 6'h09;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // REGIMM branches are selected by the rt field.
    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic [31:0] adr;
        logic [3:0]  sel;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_J, BR_JAL, BR_JR, BR_JALR, BR_BEQ, BR_BNE,
        BR_BGEZ, BR_BGEZAL, BR_BGTZ, BR_BLEZ, BR_BLTZ, BR_BLTZAL
    } branch_kind_e;

    typedef struct packed {
        logic [4:0]   rs;
        logic [4:0]   rt;
        logic [4:0]   wr_addr;
        logic [31:0]  imm_ext;
        logic         use_imm;
        alu_op_e      alu_op;
        logic         reg_write;
        branch_kind_e kind;
        logic [25:0]  jump_index;
        logic [4:0]   shamt;
    } ctrl_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
        logic        wr_en;
        logic [4:0]  wr_addr;
        logic [31:0] wr_data;
        logic [31:0] next_pc;
    } retire_t;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              fetch_req,
    input  logic [31:0]       fetch_adr,
    input  mips_pkg::wb_rsp_t wb_rsp,
    output mips_pkg::wb_req_t wb_req,
    output logic [31:0]       instr,
    output logic              instr_valid
);

    logic        busy; // High while a bus cycle is open.
    logic [31:0] adr_q;

    // Classic read cycle, cyc and stb follow the busy state.
    assign wb_req = '{cyc: busy, stb: busy, adr: adr_q, sel: 4'hf};

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            if (!busy) begin
                if (fetch_req) begin
                    busy <= 1'b1;
                end
            end else if (wb_rsp.ack) begin
                busy        <= 1'b0; // Ends the cycle on this edge.
                instr_valid <= 1'b1;
            end
        end
    end

    // Address and instruction word carry no reset.
    always_ff @(posedge clk) begin
        if (!busy && fetch_req) begin
            adr_q <= fetch_adr;
        end
    end

    always_ff @(posedge clk) begin
        if (busy && wb_rsp.ack) begin
            instr <= wb_rsp.dat;
        end
    end

endmodule

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  logic [31:0]     instr,
    output mips_pkg::ctrl_t ctrl
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rd;
    logic [15:0] imm;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign rd     = instr[15:11];
    assign imm    = instr[15:0];

    always_comb begin
        ctrl            = '0;
        ctrl.rs         = instr[25:21];
        ctrl.rt         = instr[20:16];
        ctrl.imm_ext    = {{16{imm[15]}}, imm}; // Sign extended by default.
        ctrl.alu_op     = mips_pkg::ALU_ADD;
        ctrl.kind       = mips_pkg::BR_NONE;
        ctrl.jump_index = instr[25:0];
        ctrl.shamt      = instr[10:6];
        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                ctrl.wr_addr   = rd;
                ctrl.reg_write = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_JALR: ctrl.kind   = mips_pkg::BR_JALR; // Links into rd.
                    mips_pkg::FN_JR: begin
                        ctrl.kind      = mips_pkg::BR_JR;
                        ctrl.reg_write = 1'b0;
                    end
                    default: ctrl.reg_write = 1'b0;
                endcase
            end
            mips_pkg::OP_REGIMM: begin
                ctrl.wr_addr = 5'd31;
                case (ctrl.rt)
                    mips_pkg::RT_BLTZ: ctrl.kind = mips_pkg::BR_BLTZ;
                    mips_pkg::RT_BGEZ: ctrl.kind = mips_pkg::BR_BGEZ;
                    mips_pkg::RT_BLTZAL: begin
                        ctrl.kind      = mips_pkg::BR_BLTZAL;
                        ctrl.reg_write = 1'b1;
                    end
                    mips_pkg::RT_BGEZAL: begin
                        ctrl.kind      = mips_pkg::BR_BGEZAL;
                        ctrl.reg_write = 1'b1;
                    end
                    default: ctrl.kind = mips_pkg::BR_NONE;
                endcase
            end
            mips_pkg::OP_J: ctrl.kind = mips_pkg::BR_J;
            mips_pkg::OP_JAL: begin
                ctrl.kind      = mips_pkg::BR_JAL;
                ctrl.wr_addr   = 5'd31;
                ctrl.reg_write = 1'b1;
            end
            mips_pkg::OP_BEQ:  ctrl.kind = mips_pkg::BR_BEQ;
            mips_pkg::OP_BNE:  ctrl.kind = mips_pkg::BR_BNE;
            mips_pkg::OP_BLEZ: ctrl.kind = mips_pkg::BR_BLEZ;
            mips_pkg::OP_BGTZ: ctrl.kind = mips_pkg::BR_BGTZ;
            mips_pkg::OP_ADDIU, mips_pkg::OP_ORI, mips_pkg::OP_LUI: begin
                ctrl.wr_addr   = ctrl.rt;
                ctrl.use_imm   = 1'b1;
                ctrl.reg_write = 1'b1;
                if (opcode == mips_pkg::OP_ORI) begin
                    ctrl.imm_ext = {16'h0000, imm};
                    ctrl.alu_op  = mips_pkg::ALU_OR;
                end else if (opcode == mips_pkg::OP_LUI) begin
                    ctrl.imm_ext = {imm, 16'h0000};
                    ctrl.alu_op  = mips_pkg::ALU_LUI;
                end
            end
            default: ctrl.reg_write = 1'b0; // Unknown opcode retires as a no-op.
        endcase
    end

endmodule

`default_nettype wire

//--- reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_val,
    output logic [31:0] rt_val
);

    logic [31:0] regs [32];

    // Register zero is never written, so it reads zero.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_val = regs[rs_addr];
    assign rt_val = regs[rt_addr];

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  mips_pkg::alu_op_e op,
    input  logic [4:0]        shamt,
    output logic [31:0]       result
);

    logic [31:0] diff;
    logic        less;

    assign diff = a - b;

    // Signed compare from the subtraction and the operand signs.
    always_comb begin
        if (a[31] != b[31]) begin
            less = a[31];
        end else begin
            less = diff[31];
        end
    end

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: result = a + b;
            mips_pkg::ALU_SUB: result = diff;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_XOR: result = a ^ b;
            mips_pkg::ALU_SLT: result = {31'd0, less};
            mips_pkg::ALU_SLL: result = b << shamt; // Shifts rt, not rs.
            mips_pkg::ALU_LUI: result = b; // Immediate already in the upper half.
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- next_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc_unit #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  mips_pkg::ctrl_t ctrl,
    input  logic [31:0]     rs_val,
    input  logic [31:0]     rt_val,
    output logic            fetch_req,
    output logic [31:0]     pc,
    output logic [31:0]     next_pc,
    output logic            execute,
    output logic            link_en,
    output logic [31:0]     link_data
);

    logic        exec_phase; // Low for fetch, high for execute.
    logic [31:0] pc4;
    logic [31:0] br_tgt;
    logic [31:0] jump_tgt;
    logic        br_taken;

    assign pc4      = pc + 32'd4;
    assign br_tgt   = pc4 + {ctrl.imm_ext[29:0], 2'b00};
    assign jump_tgt = {pc4[31:28], ctrl.jump_index, 2'b00};

    // Only place the branch condition is tested.
    always_comb begin
        case (ctrl.kind)
            mips_pkg::BR_BEQ:                       br_taken = rs_val == rt_val;
            mips_pkg::BR_BNE:                       br_taken = rs_val != rt_val;
            mips_pkg::BR_BGEZ, mips_pkg::BR_BGEZAL: br_taken = !rs_val[31];
            mips_pkg::BR_BGTZ:                      br_taken = $signed(rs_val) > 32'sd0;
            mips_pkg::BR_BLEZ:                      br_taken = $signed(rs_val) <= 32'sd0;
            mips_pkg::BR_BLTZ, mips_pkg::BR_BLTZAL: br_taken = rs_val[31];
            default:                                br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl.kind)
            mips_pkg::BR_J, mips_pkg::BR_JAL:   next_pc = jump_tgt;
            mips_pkg::BR_JR, mips_pkg::BR_JALR: next_pc = rs_val;
            default:                            next_pc = br_taken ? br_tgt : pc4;
        endcase
    end

    // Linking kinds write pc4 whether or not a branch is taken.
    assign link_en = ctrl.kind inside {mips_pkg::BR_JAL, mips_pkg::BR_JALR,
                                       mips_pkg::BR_BGEZAL, mips_pkg::BR_BLTZAL};
    assign link_data = pc4;

    assign fetch_req = !exec_phase; // One-cycle request per instruction.
    assign execute   = exec_phase && instr_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            exec_phase <= 1'b0;
        end else if (!exec_phase) begin
            exec_phase <= 1'b1;
        end else if (instr_valid) begin
            pc         <= next_pc;
            exec_phase <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  logic              clk,
    input  logic              rst,
    input  mips_pkg::wb_rsp_t wb_rsp,
    output mips_pkg::wb_req_t wb_req,
    output mips_pkg::retire_t retire
);

    logic            fetch_req;
    logic [31:0]     pc;
    logic [31:0]     next_pc;
    logic [31:0]     instr;
    logic            instr_valid;
    logic            execute;
    logic            link_en;
    logic [31:0]     link_data;
    mips_pkg::ctrl_t ctrl;
    logic [31:0]     rs_val;
    logic [31:0]     rt_val;
    logic [31:0]     alu_b;
    logic [31:0]     alu_result;
    logic [31:0]     wr_data;
    logic            wr_en;

    assign alu_b   = ctrl.use_imm ? ctrl.imm_ext : rt_val;
    assign wr_data = link_en ? link_data : alu_result;
    assign wr_en   = execute && ctrl.reg_write && ctrl.wr_addr != 5'd0;

    fetch_unit fetch_unit_inst (
        .clk(clk), .rst(rst), .fetch_req(fetch_req), .fetch_adr(pc),
        .wb_rsp(wb_rsp), .wb_req(wb_req), .instr(instr), .instr_valid(instr_valid)
    );

    instr_decoder instr_decoder_inst (.instr(instr), .ctrl(ctrl));

    reg_file reg_file_inst (
        .clk(clk), .rst(rst), .rs_addr(ctrl.rs), .rt_addr(ctrl.rt),
        .wr_en(wr_en), .wr_addr(ctrl.wr_addr), .wr_data(wr_data),
        .rs_val(rs_val), .rt_val(rt_val)
    );

    alu alu_inst (
        .a(rs_val), .b(alu_b), .op(ctrl.alu_op), .shamt(ctrl.shamt), .result(alu_result)
    );

    next_pc_unit #(.RESET_PC(RESET_PC)) next_pc_unit_inst (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .ctrl(ctrl),
        .rs_val(rs_val), .rt_val(rt_val), .fetch_req(fetch_req), .pc(pc),
        .next_pc(next_pc), .execute(execute), .link_en(link_en), .link_data(link_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            retire.valid <= 1'b0;
        end else begin
            retire.valid <= execute; // One cycle after the execute strobe.
        end
    end

    always_ff @(posedge clk) begin
        if (execute) begin
            retire.pc      <= pc;
            retire.instr   <= instr;
            retire.wr_en   <= wr_en;
            retire.wr_addr <= ctrl.wr_addr;
            retire.wr_data <= wr_data;
            retire.next_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

//--- mips_core_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core_asserts (
    input logic              clk,
    input logic              rst,
    input mips_pkg::wb_req_t wb_req,
    input mips_pkg::wb_rsp_t wb_rsp,
    input mips_pkg::retire_t retire
);

    cyc_stb_equal: assert property (@(posedge clk) disable iff (rst)
        wb_req.cyc == wb_req.stb)
        else $error("Wishbone cyc and stb differ");

    // Request held through wait states.
    stb_adr_hold: assert property (@(posedge clk) disable iff (rst)
        (wb_req.stb && !wb_rsp.ack) |=> (wb_req.stb && $stable(wb_req.adr)))
        else $error("Wishbone stb or adr changed before ack");

    retire_bus_idle: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> !wb_req.cyc)
        else $error("Retire while a bus cycle is open");

    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        retire.valid |-> !(retire.wr_en && retire.wr_addr == 5'd0))
        else $error("Retire shows a write to register zero");

endmodule

bind mips_core mips_core_asserts mips_core_asserts_inst (
    .clk(clk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp), .retire(retire)
);

`default_nettype wire

//--- tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int MEM_WORDS = 512;
    localparam int LIMIT = 4000; // Cycles allowed per wait.

    logic clk;
    logic rst;
    mips_pkg::wb_req_t wb_req;
    mips_pkg::wb_rsp_t wb_rsp;
    mips_pkg::retire_t retire;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_regs [32];
    logic [31:0] ref_pc;
    logic [31:0] fetch_adr_last;
    mips_pkg::retire_t expected;
    int seed = 69751;
    int wait_cnt;
    int fetch_count;
    int retire_count;
    int errors;
    int tests_run;
    int tests_failed;
    int errors_before;
    int ptr;
    logic in_cycle;
    logic timed_out;
    logic [31:0] rand_base;
    logic [31:0] loop_adr;

    mips_core #(.RESET_PC(RESET_PC)) mips_core_inst (
        .clk(clk), .rst(rst), .wb_rsp(wb_rsp), .wb_req(wb_req), .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    function automatic logic [31:0] r_word(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        return {mips_pkg::OP_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [31:0] adr);
        return {op, adr[27:2]};
    endfunction

    // Architectural model, one instruction per call.
    function automatic mips_pkg::retire_t exec_ref(input logic [31:0] word);
        mips_pkg::retire_t r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] pc4;
        logic [31:0] val;
        logic [31:0] target;
        logic [4:0]  dst;
        logic        we;
        logic        taken;
        rs = word[25:21];
        rt = word[20:16];
        a = ref_regs[rs];
        b = ref_regs[rt];
        sext = {{16{word[15]}}, word[15:0]};
        pc4 = ref_pc + 32'd4;
        val = '0;
        dst = '0;
        we = 1'b0;
        taken = 1'b0;
        target = pc4;
        case (word[31:26])
            mips_pkg::OP_SPECIAL: begin
                dst = word[15:11];
                we = 1'b1;
                case (word[5:0])
                    mips_pkg::FN_ADDU: val = a + b;
                    mips_pkg::FN_SUBU: val = a - b;
                    mips_pkg::FN_AND:  val = a & b;
                    mips_pkg::FN_OR:   val = a | b;
                    mips_pkg::FN_XOR:  val = a ^ b;
                    mips_pkg::FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    mips_pkg::FN_SLL:  val = b << word[10:6];
                    mips_pkg::FN_JR: begin
                        we = 1'b0;
                        target = a;
                    end
                    mips_pkg::FN_JALR: begin
                        val = pc4;
                        target = a;
                    end
                    default: we = 1'b0;
                endcase
            end
            mips_pkg::OP_REGIMM: begin
                case (rt)
                    mips_pkg::RT_BLTZ: taken = a[31];
                    mips_pkg::RT_BGEZ: taken = !a[31];
                    mips_pkg::RT_BLTZAL, mips_pkg::RT_BGEZAL: begin
                        taken = (rt == mips_pkg::RT_BLTZAL) ? a[31] : !a[31];
                        we = 1'b1; // Links even when not taken.
                        dst = 5'd31;
                        val = pc4;
                    end
                    default: taken = 1'b0;
                endcase
            end
            mips_pkg::OP_J: target = {pc4[31:28], word[25:0], 2'b00};
            mips_pkg::OP_JAL: begin
                target = {pc4[31:28], word[25:0], 2'b00};
                we = 1'b1;
                dst = 5'd31;
                val = pc4;
            end
            mips_pkg::OP_BEQ:  taken = a == b;
            mips_pkg::OP_BNE:  taken = a != b;
            mips_pkg::OP_BLEZ: taken = $signed(a) <= 32'sd0;
            mips_pkg::OP_BGTZ: taken = $signed(a) > 32'sd0;
            mips_pkg::OP_ADDIU: begin
                we = 1'b1;
                dst = rt;
                val = a + sext;
            end
            mips_pkg::OP_ORI: begin
                we = 1'b1;
                dst = rt;
                val = a | {16'h0000, word[15:0]};
            end
            mips_pkg::OP_LUI: begin
                we = 1'b1;
                dst = rt;
                val = {word[15:0], 16'h0000};
            end
            default: we = 1'b0;
        endcase
        if (taken) begin
            target = pc4 + {sext[29:0], 2'b00};
        end
        r = '0;
        r.valid = 1'b1;
        r.pc = ref_pc;
        r.instr = word;
        r.wr_en = we && dst != 5'd0;
        r.wr_addr = dst;
        r.wr_data = val;
        r.next_pc = target;
        if (r.wr_en) begin
            ref_regs[dst] = val;
        end
        ref_pc = target;
        return r;
    endfunction

    task automatic put_word(input logic [31:0] word);
        mem[ptr] = word;
        ptr++;
    endtask

    // Branch over one filler word.
    task automatic put_skip(input logic [31:0] word);
        put_word(word);
        put_word(i_word(mips_pkg::OP_ADDIU, 5'd10, 5'd10, 16'd1));
    endtask

    task automatic build_program();
        int k;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [15:0] imm;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hfc00_0000 | 32'(i); // Unknown opcode, tagged by address.
        end
        ptr = int'(RESET_PC >> 2);
        put_word(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd1, 16'd5));
        put_word(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd2, 16'hfffd));
        put_word(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd3, 16'd5));
        put_skip(i_word(mips_pkg::OP_BEQ, 5'd1, 5'd3, 16'd1));
        put_skip(i_word(mips_pkg::OP_BEQ, 5'd1, 5'd2, 16'd1));
        put_skip(i_word(mips_pkg::OP_BNE, 5'd1, 5'd2, 16'd1));
        put_skip(i_word(mips_pkg::OP_BNE, 5'd1, 5'd3, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RT_BGEZ, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd2, mips_pkg::RT_BGEZ, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd0, mips_pkg::RT_BGEZ, 16'd1));
        put_skip(i_word(mips_pkg::OP_BGTZ, 5'd1, 5'd0, 16'd1));
        put_skip(i_word(mips_pkg::OP_BGTZ, 5'd0, 5'd0, 16'd1));
        put_skip(i_word(mips_pkg::OP_BGTZ, 5'd2, 5'd0, 16'd1));
        put_skip(i_word(mips_pkg::OP_BLEZ, 5'd0, 5'd0, 16'd1));
        put_skip(i_word(mips_pkg::OP_BLEZ, 5'd2, 5'd0, 16'd1));
        put_skip(i_word(mips_pkg::OP_BLEZ, 5'd1, 5'd0, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd2, mips_pkg::RT_BLTZ, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd0, mips_pkg::RT_BLTZ, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RT_BGEZAL, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd1, mips_pkg::RT_BLTZAL, 16'd1));
        put_skip(i_word(mips_pkg::OP_REGIMM, 5'd2, mips_pkg::RT_BLTZAL, 16'd1));
        put_word(i_word(mips_pkg::OP_ADDIU, 5'd1, 5'd0, 16'd7)); // Write to r0.
        put_word(32'hf800_1234);
        put_word(r_word(6'h3f, 5'd1, 5'd2, 5'd6, 5'd0));
        put_skip(j_word(mips_pkg::OP_J, 32'(ptr + 2) << 2));
        put_skip(j_word(mips_pkg::OP_JAL, 32'(ptr + 2) << 2));
        put_word(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd4, 16'(32'(ptr + 3) << 2)));
        put_skip(r_word(mips_pkg::FN_JR, 5'd4, 5'd0, 5'd0, 5'd0));
        put_word(i_word(mips_pkg::OP_ADDIU, 5'd0, 5'd4, 16'(32'(ptr + 3) << 2)));
        put_skip(r_word(mips_pkg::FN_JALR, 5'd4, 5'd0, 5'd5, 5'd0));
        rand_base = 32'(ptr) << 2;
        for (int n = 0; n < 200; n++) begin
            k = {$random(seed)} % 10;
            rs = 5'({$random(seed)} % 32);
            rt = 5'({$random(seed)} % 32);
            rd = 5'({$random(seed)} % 31); // Never r31.
            imm = 16'($random(seed));
            case (k)
                0: put_word(r_word(mips_pkg::FN_ADDU, rs, rt, rd, 5'd0));
                1: put_word(r_word(mips_pkg::FN_SUBU, rs, rt, rd, 5'd0));
                2: put_word(r_word(mips_pkg::FN_AND, rs, rt, rd, 5'd0));
                3: put_word(r_word(mips_pkg::FN_OR, rs, rt, rd, 5'd0));
                4: put_word(r_word(mips_pkg::FN_XOR, rs, rt, rd, 5'd0));
                5: put_word(r_word(mips_pkg::FN_SLT, rs, rt, rd, 5'd0));
                6: put_word(r_word(mips_pkg::FN_SLL, 5'd0, rt, rd, imm[4:0]));
                7: put_word(i_word(mips_pkg::OP_ADDIU, rs, rd, imm));
                8: put_word(i_word(mips_pkg::OP_ORI, rs, rd, imm));
                default: put_word(i_word(mips_pkg::OP_LUI, 5'd0, rd, imm));
            endcase
        end
        loop_adr = 32'(ptr) << 2;
        put_word(i_word(mips_pkg::OP_BEQ, 5'd0, 5'd0, 16'hffff));
    endtask

    // Wishbone slave with 0 to 3 wait states.
    always @(negedge clk) begin
        if (rst) begin
            wb_rsp = '0;
            in_cycle = 1'b0;
        end else if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
            in_cycle = 1'b0;
        end else if (wb_req.cyc && wb_req.stb) begin
            if (!in_cycle) begin
                in_cycle = 1'b1;
                fetch_adr_last = wb_req.adr;
                fetch_count++;
                assert (wb_req.sel == 4'hf)
                    else report_mismatch("sel", 32'(wb_req.sel), 32'hf);
            end
            if (wait_cnt == 0) begin
                wb_rsp.ack = 1'b1;
                wb_rsp.dat = mem[wb_req.adr[10:2]];
            end else begin
                wait_cnt--;
            end
        end else begin
            wait_cnt = {$random(seed)} % 4;
        end
    end

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, want);
        errors++;
    endtask

    // Comparator.
    always @(negedge clk) begin
        if (!rst && retire.valid) begin
            expected = exec_ref(mem[ref_pc[10:2]]);
            assert (retire.pc == expected.pc)
                else report_mismatch("pc", retire.pc, expected.pc);
            assert (retire.instr == expected.instr)
                else report_mismatch("instr", retire.instr, expected.instr);
            assert (fetch_adr_last == expected.pc)
                else report_mismatch("fetch address", fetch_adr_last, expected.pc);
            assert (retire.wr_en == expected.wr_en)
                else report_mismatch("wr_en", 32'(retire.wr_en), 32'(expected.wr_en));
            if (expected.wr_en) begin
                assert (retire.wr_addr == expected.wr_addr)
                    else report_mismatch("wr_addr", 32'(retire.wr_addr), 32'(expected.wr_addr));
                assert (retire.wr_data == expected.wr_data)
                    else report_mismatch("wr_data", retire.wr_data, expected.wr_data);
            end
            assert (retire.next_pc == expected.next_pc)
                else report_mismatch("next_pc", retire.next_pc, expected.next_pc);
            retire_count++;
        end
    end

    task automatic wait_for_pc(input logic [31:0] adr);
        int cnt;
        cnt = 0;
        while (!timed_out && ref_pc != adr && cnt < LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!timed_out && ref_pc != adr) begin
            timed_out = 1'b1;
            $display("Timeout: the core stopped retiring before pc %h", adr);
        end
    endtask

    task automatic wait_for_retires(input int n);
        int cnt;
        cnt = 0;
        while (!timed_out && retire_count < n && cnt < LIMIT) begin
            @(negedge clk);
            cnt++;
        end
        if (!timed_out && retire_count < n) begin
            timed_out = 1'b1;
            $display("Timeout: the core stopped retiring after %0d instructions", retire_count);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != errors_before || timed_out) begin
            tests_failed++;
            $display("Test %s: FAIL", name);
        end else begin
            $display("Test %s: PASS", name);
        end
        errors_before = errors;
    endtask

    initial begin
        int cnt;
        rst = 1'b1;
        wb_rsp = '0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = RESET_PC;
        fetch_adr_last = '0;
        wait_cnt = 0;
        fetch_count = 0;
        retire_count = 0;
        errors = 0;
        errors_before = 0;
        tests_run = 0;
        tests_failed = 0;
        in_cycle = 1'b0;
        timed_out = 1'b0;
        build_program();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (!wb_req.cyc && !wb_req.stb)
            else report_mismatch("cyc/stb after reset", 32'(wb_req.cyc), 32'd0);
        cnt = 0;
        while (fetch_count == 0 && cnt < 2) begin
            @(negedge clk);
            cnt++;
        end
        if (fetch_count == 0) begin
            timed_out = 1'b1;
            $display("Timeout: no bus cycle started within two cycles of reset");
        end else begin
            assert (fetch_adr_last == RESET_PC)
                else report_mismatch("first fetch address", fetch_adr_last, RESET_PC);
        end
        wait_for_retires(1);
        finish_test("reset_state");
        wait_for_pc(rand_base);
        finish_test("directed_branches_jumps");
        wait_for_pc(loop_adr);
        finish_test("random_alu_program");
        wait_for_retires(retire_count + 3);
        assert (retire.pc == loop_adr)
            else report_mismatch("self loop pc", retire.pc, loop_adr);
        assert (retire.next_pc == loop_adr)
            else report_mismatch("self loop next_pc", retire.next_pc, loop_adr);
        finish_test("self_loop");
        $display("Summary: %0d tests, %0d failed, %0d retired, %0d mismatches",
                 tests_run, tests_failed, retire_count, errors);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
mips_pkg.sv
fetch_unit.sv
instr_decoder.sv
reg_file.sv
alu.sv
next_pc_unit.sv
mips_core.sv
mips_core_asserts.sv
tb_mips_core.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the MIPS core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_mips_core -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
exit 0
